/* source/dtm_pkg.sv */
// shared DTM definitions; IR width and register values are fixed, only the success status is produced
package dtm_pkg;

    // instruction register and codes
    localparam int ir_width_c = 5;
    localparam logic [ir_width_c-1:0] instr_idcode_c = 5'h01;
    localparam logic [ir_width_c-1:0] instr_dmi_c    = 5'h11;
    localparam logic [ir_width_c-1:0] instr_bypass_c = 5'h1f;
    localparam logic [31:0] idcode_value_c = 32'h1234_5678;

    // dmi word layout, address on top and op in the two lsbs
    localparam int dmi_addr_width_c = 10;
    localparam int dmi_data_width_c = 32;
    localparam int dmi_op_width_c   = 2;
    localparam int dmi_width_c      = dmi_addr_width_c + dmi_data_width_c + dmi_op_width_c;

    typedef enum logic [dmi_op_width_c-1:0] {
        dmi_op_nop      = 2'd0,
        dmi_op_read     = 2'd1,
        dmi_op_write    = 2'd2,
        dmi_op_reserved = 2'd3
    } dmi_op_e;

    typedef enum logic [dmi_op_width_c-1:0] {
        dmi_status_success = 2'd0,
        dmi_status_failed  = 2'd2,
        dmi_status_busy    = 2'd3
    } dmi_status_e;

    typedef struct packed {
        logic [dmi_addr_width_c-1:0] addr;
        logic [dmi_data_width_c-1:0] data;
        dmi_op_e                     op;
    } dmi_req_t;

    typedef struct packed {
        logic [dmi_addr_width_c-1:0] addr;
        logic [dmi_data_width_c-1:0] data;
        dmi_status_e                 status;
    } dmi_resp_t;

    // same 44 bits, request going in and response coming out
    typedef union packed {
        dmi_req_t  req;
        dmi_resp_t resp;
    } dmi_word_u;

    // standard 1149.1 state set
    typedef enum logic [3:0] {
        tap_tlr      = 4'd0,
        tap_rti      = 4'd1,
        tap_sel_dr   = 4'd2,
        tap_cap_dr   = 4'd3,
        tap_shift_dr = 4'd4,
        tap_exit1_dr = 4'd5,
        tap_pause_dr = 4'd6,
        tap_exit2_dr = 4'd7,
        tap_upd_dr   = 4'd8,
        tap_sel_ir   = 4'd9,
        tap_cap_ir   = 4'd10,
        tap_shift_ir = 4'd11,
        tap_exit1_ir = 4'd12,
        tap_pause_ir = 4'd13,
        tap_exit2_ir = 4'd14,
        tap_upd_ir   = 4'd15
    } tap_state_e;

    // raw pins, asynchronous to clk
    typedef struct packed {
        logic tck;
        logic tms;
        logic tdi;
    } jtag_pins_t;

    // one-clk strobes plus pins sampled with them
    typedef struct packed {
        logic tck_rise;
        logic tck_fall;
        logic tms;
        logic tdi;
    } tap_step_t;

    typedef struct packed {
        logic                        write;
        logic [dmi_addr_width_c-1:0] addr;
        logic [dmi_data_width_c-1:0] wdata;
    } bus_cmd_t;

endpackage

/* source/jtag_pin_sync.sv */
// tck must stay high and low for at least three clk each, or edges are lost
`timescale 1ns/1ns

module jtag_pin_sync
(
    input  logic                clk,
    input  logic                rst_n,
    input  dtm_pkg::jtag_pins_t pins_i,
    output dtm_pkg::tap_step_t  step_o
);
    import dtm_pkg::*;

    // two-flop synchroniser on all three pins
    jtag_pins_t sync1_q;
    jtag_pins_t sync2_q;
    // previous synchronised tck for edge detect
    logic       tck_prev_q;
    tap_step_t  step_q;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            sync1_q    <= '0;
            sync2_q    <= '0;
            tck_prev_q <= 1'b0;
            step_q     <= '0;
        end
        else
        begin
            sync1_q    <= pins_i;
            sync2_q    <= sync1_q;
            tck_prev_q <= sync2_q.tck;
            // strobes last a single clk, tms and tdi ride along
            step_q.tck_rise <= sync2_q.tck & ~tck_prev_q;
            step_q.tck_fall <= ~sync2_q.tck & tck_prev_q;
            step_q.tms      <= sync2_q.tms;
            step_q.tdi      <= sync2_q.tdi;
        end
    end

    assign step_o = step_q;

endmodule

/* source/tap_fsm.sv */
// state only moves on a tck rising strobe; five tms-high steps always reach test-logic-reset
`timescale 1ns/1ns

module tap_fsm
(
    input  logic                clk,
    input  logic                rst_n,
    input  dtm_pkg::tap_step_t  step_i,
    output dtm_pkg::tap_state_e state_o
);
    import dtm_pkg::*;

    tap_state_e state_q;
    tap_state_e state_next;

    // 1149.1 transition table, tms picks the branch
    always_comb
    begin
        case (state_q)
            tap_tlr:      state_next = step_i.tms ? tap_tlr      : tap_rti;
            tap_rti:      state_next = step_i.tms ? tap_sel_dr   : tap_rti;
            tap_sel_dr:   state_next = step_i.tms ? tap_sel_ir   : tap_cap_dr;
            tap_cap_dr:   state_next = step_i.tms ? tap_exit1_dr : tap_shift_dr;
            tap_shift_dr: state_next = step_i.tms ? tap_exit1_dr : tap_shift_dr;
            tap_exit1_dr: state_next = step_i.tms ? tap_upd_dr   : tap_pause_dr;
            tap_pause_dr: state_next = step_i.tms ? tap_exit2_dr : tap_pause_dr;
            tap_exit2_dr: state_next = step_i.tms ? tap_upd_dr   : tap_shift_dr;
            tap_upd_dr:   state_next = step_i.tms ? tap_sel_dr   : tap_rti;
            tap_sel_ir:   state_next = step_i.tms ? tap_tlr      : tap_cap_ir;
            tap_cap_ir:   state_next = step_i.tms ? tap_exit1_ir : tap_shift_ir;
            tap_shift_ir: state_next = step_i.tms ? tap_exit1_ir : tap_shift_ir;
            tap_exit1_ir: state_next = step_i.tms ? tap_upd_ir   : tap_pause_ir;
            tap_pause_ir: state_next = step_i.tms ? tap_exit2_ir : tap_pause_ir;
            tap_exit2_ir: state_next = step_i.tms ? tap_upd_ir   : tap_shift_ir;
            tap_upd_ir:   state_next = step_i.tms ? tap_sel_dr   : tap_rti;
            default:      state_next = tap_tlr;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state_q <= tap_tlr;
        end
        else if (step_i.tck_rise)
        begin
            state_q <= state_next;
        end
    end

    assign state_o = state_q;

    // never an unknown state once out of reset
    a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(state_q));

endmodule

/* source/tap_regs.sv */
// any instruction other than IDCODE or DMI selects BYPASS; TDO is driven low outside shift states
`timescale 1ns/1ns

module tap_regs
(
    input  logic                                clk,
    input  logic                                rst_n,
    input  dtm_pkg::tap_step_t                  step_i,
    input  dtm_pkg::tap_state_e                 state_i,
    input  logic                                dmi_tdo_i,
    output logic [dtm_pkg::ir_width_c-1:0]      ir_o,
    output logic                                tdo_o
);
    import dtm_pkg::*;

    logic [ir_width_c-1:0] ir_q;
    logic [ir_width_c-1:0] ir_shift_q;
    logic [31:0]           idcode_shift_q;
    logic                  bypass_shift_q;
    logic                  tdo_q;
    logic                  sel_idcode;
    logic                  sel_dmi;

    assign sel_idcode = (ir_q == instr_idcode_c);
    assign sel_dmi    = (ir_q == instr_dmi_c);

    // held instruction, back to IDCODE in test-logic-reset
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ir_q <= instr_idcode_c;
        end
        else if (step_i.tck_rise)
        begin
            if (state_i == tap_tlr)
            begin
                ir_q <= instr_idcode_c;
            end
            else if (state_i == tap_upd_ir)
            begin
                ir_q <= ir_shift_q;
            end
        end
    end

    // shift paths, lsb leaves first
    always_ff @(posedge clk)
    begin
        if (step_i.tck_rise)
        begin
            case (state_i)
                tap_cap_ir:   ir_shift_q <= ir_q;
                tap_shift_ir: ir_shift_q <= {step_i.tdi, ir_shift_q[ir_width_c-1:1]};
                tap_cap_dr:
                begin
                    idcode_shift_q <= idcode_value_c;
                    // bypass always captures zero
                    bypass_shift_q <= 1'b0;
                end
                tap_shift_dr:
                begin
                    if (sel_idcode)
                    begin
                        idcode_shift_q <= {step_i.tdi, idcode_shift_q[31:1]};
                    end
                    bypass_shift_q <= step_i.tdi;
                end
                default:
                begin
                end
            endcase
        end
    end

    // tdo reloads on falling tck
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            tdo_q <= 1'b0;
        end
        else if (step_i.tck_fall)
        begin
            if (state_i == tap_shift_ir)
            begin
                tdo_q <= ir_shift_q[0];
            end
            else if (state_i == tap_shift_dr)
            begin
                tdo_q <= sel_idcode ? idcode_shift_q[0] :
                         sel_dmi    ? dmi_tdo_i         : bypass_shift_q;
            end
            else
            begin
                tdo_q <= 1'b0;
            end
        end
    end

    assign ir_o  = ir_q;
    assign tdo_o = tdo_q;

endmodule

/* source/dmi_port.sv */
// one bus transaction at a time; an Update-DR while the handshake is busy is not allowed
`timescale 1ns/1ns

module dmi_port
(
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  dtm_pkg::tap_step_t                   step_i,
    input  dtm_pkg::tap_state_e                  state_i,
    input  logic [dtm_pkg::ir_width_c-1:0]       ir_i,
    output logic                                 dmi_tdo_o,
    output logic                                 bus_req_o,
    output dtm_pkg::bus_cmd_t                    bus_cmd_o,
    input  logic                                 bus_ack_i,
    input  logic [dtm_pkg::dmi_data_width_c-1:0] bus_rdata_i
);
    import dtm_pkg::*;

    dmi_word_u shift_q;
    // hold register, read back by the next capture
    dmi_word_u hold_q;
    bus_cmd_t  cmd_q;
    logic      req_q;
    // ack seen, waiting for it to drop
    logic      wait_q;
    logic      busy;
    logic      sel_dmi;
    logic      update_dmi;

    assign sel_dmi    = (ir_i == instr_dmi_c);
    assign update_dmi = step_i.tck_rise && sel_dmi && (state_i == tap_upd_dr);
    assign busy       = req_q || wait_q;

    // 44-bit scan chain
    always_ff @(posedge clk)
    begin
        if (step_i.tck_rise && sel_dmi)
        begin
            if (state_i == tap_cap_dr)
            begin
                shift_q <= hold_q;
            end
            else if (state_i == tap_shift_dr)
            begin
                shift_q <= {step_i.tdi, shift_q[dmi_width_c-1:1]};
            end
        end
    end

    // command latched at update, stable while req is high
    always_ff @(posedge clk)
    begin
        if (update_dmi)
        begin
            cmd_q <= '{write: (shift_q.req.op == dmi_op_write),
                       addr:  shift_q.req.addr,
                       wdata: shift_q.req.data};
        end
    end

    // four-phase handshake and response word
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            hold_q <= '0;
            req_q  <= 1'b0;
            wait_q <= 1'b0;
        end
        else if (update_dmi)
        begin
            hold_q.resp <= '{addr:   shift_q.req.addr,
                             data:   shift_q.req.data,
                             status: dmi_status_success};
            // nop and reserved leave the bus alone
            if (shift_q.req.op inside {dmi_op_read, dmi_op_write})
            begin
                req_q <= 1'b1;
            end
        end
        else if (req_q && bus_ack_i)
        begin
            req_q  <= 1'b0;
            wait_q <= 1'b1;
            // read data is valid while ack is high
            if (!cmd_q.write)
            begin
                hold_q.resp.data <= bus_rdata_i;
            end
        end
        else if (wait_q && !bus_ack_i)
        begin
            wait_q <= 1'b0;
        end
    end

    assign dmi_tdo_o = shift_q[0];
    assign bus_req_o = req_q;
    assign bus_cmd_o = cmd_q;

    // req may only drop after the responder acks
    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        bus_req_o && !bus_ack_i |=> bus_req_o);

    // host must not update the DMI register mid-transaction
    a_no_update_busy: assert property (@(posedge clk) disable iff (!rst_n)
        update_dmi |-> !busy);

endmodule

/* source/dtm_top.sv */
// JTAG pins are sampled in the clk domain, so clk must run well above eight times tck
`timescale 1ns/1ns

module dtm_top
(
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  dtm_pkg::jtag_pins_t                  jtag_pins_i,
    output logic                                 jtag_tdo_o,
    output logic                                 bus_req_o,
    output dtm_pkg::bus_cmd_t                    bus_cmd_o,
    input  logic                                 bus_ack_i,
    input  logic [dtm_pkg::dmi_data_width_c-1:0] bus_rdata_i
);
    import dtm_pkg::*;

    tap_step_t             tap_step;
    tap_state_e            tap_state;
    logic [ir_width_c-1:0] ir;
    logic                  dmi_tdo_bit;

    // pins into clk, tck edges as strobes
    jtag_pin_sync i_pin_sync (
        .clk    (clk),
        .rst_n  (rst_n),
        .pins_i (jtag_pins_i),
        .step_o (tap_step)
    );

    tap_fsm i_tap_fsm (
        .clk     (clk),
        .rst_n   (rst_n),
        .step_i  (tap_step),
        .state_o (tap_state)
    );

    // IR, IDCODE, BYPASS and the TDO mux
    tap_regs i_tap_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .step_i    (tap_step),
        .state_i   (tap_state),
        .dmi_tdo_i (dmi_tdo_bit),
        .ir_o      (ir),
        .tdo_o     (jtag_tdo_o)
    );

    // DMI register and debug module bus
    dmi_port i_dmi_port (
        .clk         (clk),
        .rst_n       (rst_n),
        .step_i      (tap_step),
        .state_i     (tap_state),
        .ir_i        (ir),
        .dmi_tdo_o   (dmi_tdo_bit),
        .bus_req_o   (bus_req_o),
        .bus_cmd_o   (bus_cmd_o),
        .bus_ack_i   (bus_ack_i),
        .bus_rdata_i (bus_rdata_i)
    );

endmodule

/* testbench/tb_dtm.sv */
// run from the project root so the vector file is found; every scan starts and ends in Run-Test/Idle
`timescale 1ns/1ns

module tb_dtm;
    import dtm_pkg::*;

    localparam int max_vectors_c = 64;

    logic                        clk;
    logic                        rst_n;
    jtag_pins_t                  pins;
    logic                        jtag_tdo;
    logic                        bus_req;
    bus_cmd_t                    bus_cmd;
    logic                        bus_ack;
    logic [dmi_data_width_c-1:0] bus_rdata;

    // debug module model storage, indexed by low address bits
    logic [31:0] mem [16];
    logic [7:0]  lfsr_q = 8'd23;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    // vectors as read from the data file
    logic [7:0]  vec_kind  [max_vectors_c];
    int          vec_bits  [max_vectors_c];
    logic [63:0] vec_tdi   [max_vectors_c];
    logic [63:0] vec_exp   [max_vectors_c];
    logic        vec_pause [max_vectors_c];
    int          vec_count = 0;

    dtm_top i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .jtag_pins_i (pins),
        .jtag_tdo_o  (jtag_tdo),
        .bus_req_o   (bus_req),
        .bus_cmd_o   (bus_cmd),
        .bus_ack_i   (bus_ack),
        .bus_rdata_i (bus_rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // n rising edges, then a short hold-off before driving
    task automatic wait_clks(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    // 8-bit fibonacci lfsr, taps 8 6 5 4
    function automatic logic next_random_bit();
        logic fb;
        fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];
        lfsr_q = {lfsr_q[6:0], fb};
        return fb;
    endfunction

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("Error at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            $display("TB FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // one tck period of 16 clk; tms/tdi set mid-low, tdo taken just before the rise
    task automatic tck_cycle(input logic tms, input logic tdi, output logic tdo);
        wait_clks(4);
        pins.tms = tms;
        pins.tdi = tdi;
        wait_clks(4);
        tdo = jtag_tdo;
        pins.tck = 1'b1;
        wait_clks(8);
        pins.tck = 1'b0;
    endtask

    task automatic run_scan(input logic is_ir, input int nbits, input logic [63:0] tdi_word,
                            input logic pause, output logic [63:0] tdo_word);
        logic tdo;
        logic last;
        logic brk;
        int   half;
        half     = nbits / 2;
        tdo_word = '0;
        // the DMI register may only update once the bus is idle
        while (bus_req || bus_ack)
            wait_clks(1);
        tck_cycle(1'b1, 1'b0, tdo);
        if (is_ir)
            tck_cycle(1'b1, 1'b0, tdo);
        // capture, then into shift
        tck_cycle(1'b0, 1'b0, tdo);
        tck_cycle(1'b0, 1'b0, tdo);
        for (int i = 0; i < nbits; i++)
        begin
            last = (i == nbits - 1);
            brk  = pause && !last && (i == half - 1);
            tck_cycle(last || brk, tdi_word[i], tdo);
            tdo_word[i] = tdo;
            if (brk)
            begin
                // exit1 -> pause -> exit2 -> back to shift
                tck_cycle(1'b0, 1'b0, tdo);
                tck_cycle(1'b1, 1'b0, tdo);
                tck_cycle(1'b0, 1'b0, tdo);
            end
        end
        // update, then idle
        tck_cycle(1'b1, 1'b0, tdo);
        tck_cycle(1'b0, 1'b0, tdo);
    endtask

    // five tms-high steps reach test-logic-reset from anywhere
    task automatic tap_reset();
        logic tdo;
        repeat (5) tck_cycle(1'b1, 1'b0, tdo);
        tck_cycle(1'b0, 1'b0, tdo);
    endtask

    task automatic load_vectors();
        int          fd;
        int          fields;
        string       line;
        logic [7:0]  kind;
        int          nbits;
        logic [63:0] tdi;
        logic [63:0] expected;
        int          pause;
        fd = $fopen("testbench/dtm_vectors.txt", "r");
        if (fd == 0)
        begin
            $display("could not open testbench/dtm_vectors.txt for reading");
            $display("TB FAILED");
            $fatal(1, "no vector file");
        end
        while ($fgets(line, fd) != 0)
        begin
            // skip comments and blank lines
            if (line.len() > 1 && line.getc(0) != "#")
            begin
                fields = $sscanf(line, "%c %d %h %h %d", kind, nbits, tdi, expected, pause);
                if (fields != 5 || vec_count >= max_vectors_c)
                begin
                    $display("vector file line could not be read: %s", line);
                    $display("TB FAILED");
                    $fatal(1, "bad vector file");
                end
                vec_kind[vec_count]  = kind;
                vec_bits[vec_count]  = nbits;
                vec_tdi[vec_count]   = tdi;
                vec_exp[vec_count]   = expected;
                vec_pause[vec_count] = (pause != 0);
                vec_count++;
            end
        end
        $fclose(fd);
    endtask

    // debug module side of the four-phase handshake
    initial
    begin
        logic [2:0] ack_delay;
        bus_ack   = 1'b0;
        bus_rdata = '0;
        for (int i = 0; i < 16; i++)
            mem[i] = 32'hcafe_0000 + i * 32'h111;
        forever
        begin
            wait_clks(1);
            if (bus_req && !bus_ack)
            begin
                // 0 to 7 clk, one lfsr step per bit
                ack_delay = '0;
                repeat (3)
                begin
                    ack_delay = {ack_delay[1:0], next_random_bit()};
                end
                repeat (ack_delay) wait_clks(1);
                if (bus_cmd.write)
                    mem[bus_cmd.addr[3:0]] = bus_cmd.wdata;
                else
                    bus_rdata = mem[bus_cmd.addr[3:0]];
                bus_ack = 1'b1;
                while (bus_req)
                    wait_clks(1);
                bus_ack = 1'b0;
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit)
        begin
            $display("timeout: the scans did not finish within %0d clk cycles", cycle_limit);
            $display("TB FAILED");
            $fatal(1, "timeout");
        end
    end

    initial
    begin
        logic [63:0] got;
        logic        tdo;
        pins  = '0;
        rst_n = 1'b0;
        load_vectors();
        // up to 64 tck periods of 16 clk per vector, plus reset and bus slack
        cycle_limit = vec_count * 64 * 16 + 4000;
        wait_clks(10);
        rst_n = 1'b1;
        // leave test-logic-reset for idle
        tck_cycle(1'b0, 1'b0, tdo);
        for (int v = 0; v < vec_count; v++)
        begin
            case (vec_kind[v])
                "R": tap_reset();
                "I":
                begin
                    run_scan(1'b1, vec_bits[v], vec_tdi[v], vec_pause[v], got);
                    check_value(got, vec_exp[v], $sformatf("vector %0d IR scan", v));
                end
                "D":
                begin
                    run_scan(1'b0, vec_bits[v], vec_tdi[v], vec_pause[v], got);
                    check_value(got, vec_exp[v], $sformatf("vector %0d DR scan", v));
                end
                default:
                begin
                    $display("vector %0d has an unknown scan kind", v);
                    $display("TB FAILED");
                    $fatal(1, "bad scan kind");
                end
            endcase
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

/* testbench/dtm_vectors.txt */
# columns: kind bits tdi_hex expected_tdo_hex pause
# kind I = IR scan, D = DR scan, R = five-TMS reset (other columns unused)
# idcode after reset, plain and paused
D 32 0 12345678 0
D 32 0 12345678 1
# load bypass, then one-bit delay
I 5 1f 01 0
D 8 a5 4a 0
D 12 3c7 78e 1
# select dmi
I 5 11 1f 0
# write 0x005 <- deadbeef, nop reads it back
D 44 177ab6fbbe 0 0
D 44 0 177ab6fbbc 0
# read 0x005 then nop
D 44 1400000001 0 0
D 44 0 177ab6fbbc 0
# write 0x3fa, read 0x003, paused nop
D 44 fe82eb7c036 0 0
D 44 c00000001 fe82eb7c034 0
D 44 0 f2bf80ccc 1
# tms reset brings idcode back
R 0 0 0 0
D 32 0 12345678 0
I 5 01 01 0

/* compile.f */
source/dtm_pkg.sv
source/jtag_pin_sync.sv
source/tap_fsm.sv
source/tap_regs.sv
source/dmi_port.sv
source/dtm_top.sv
testbench/tb_dtm.sv

/* run.sh */
#!/bin/sh
# build tb_dtm with Verilator, run it, and pass only if the pass line shows up
verilator --binary --timing --assert --top-module tb_dtm -f compile.f -o tb_dtm_sim \
    && ./obj_dir/tb_dtm_sim | tee /dev/stderr | grep -qx "TB PASSED" \
    || { echo "simulation did not pass"; exit 1; }
